//--- sources.f
+incdir+rtl
rtl/life_pkg.sv
rtl/command_decoder.sv
rtl/life_engine.sv
rtl/frame_printer.sv
rtl/conway_top.sv
verification/conway_assertions.sv
verification/conway_tb.sv

//--- verification/conway_tb.sv
/*
  game of life testbench
  drives command bytes into the top level, captures every printed
  frame with random tx back-pressure, checks the frame format and
  compares each board with a reference next generation
*/
`timescale 1ns/1ps
`default_nettype none

`include "life_defs.svh"

module conway_tb;
  import life_pkg::*;

  localparam int CELLS       = `LIFE_CELLS;
  localparam int W           = `LIFE_WIDTH;
  localparam int H           = `LIFE_HEIGHT;
  localparam int FRAME_BYTES = 4 + H * (W + 2);
  localparam int QUIET_LONG  = 3 * `LIFE_UPDATE_INTERVAL + 10000;
  // dead, random, three steps and up to four auto frames
  localparam int FRAMES_PLANNED = 9;
  localparam int TIMEOUT_CYCLES = FRAMES_PLANNED * (9000 + `LIFE_UPDATE_INTERVAL)
                                  + 100 + QUIET_LONG + 1000 + 5000;

  typedef enum {EXPECT_DEAD, EXPECT_LIVE, EXPECT_NEXT} frame_check_t;

  logic       clk;
  logic       boot_reset;
  byte_beat_t rx_beat;
  logic       rx_ready;
  byte_beat_t tx_beat;
  logic       tx_ready;

  integer           seed = 32'h74e7_1032;
  int               tx_bytes;       // accepted tx bytes so far
  int               byte_pos;       // position inside the current frame
  int               frames_checked;
  logic [CELLS-1:0] cap_board;
  logic [CELLS-1:0] ref_board;
  logic [CELLS-1:0] frame_q[$];
  frame_check_t     expect_kind;
  event             frame_done;

  conway_top u_dut (
    .clk        (clk),
    .boot_reset (boot_reset),
    .rx_beat    (rx_beat),
    .rx_ready   (rx_ready),
    .tx_beat    (tx_beat),
    .tx_ready   (tx_ready)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    #2;
    tx_ready = ($random(seed) % 4) != 0; // ready about 3 cycles in 4
  end

  task automatic fail_now(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  // the bound handshake checks count their failures
  always @(u_dut.u_assert.fail_count) begin
    assert (u_dut.u_assert.fail_count == 0)
      else fail_now("a handshake assertion on the top-level ports failed");
  end

  // toroidal life rule, cells indexed y * W + x
  function automatic logic [CELLS-1:0] next_gen(input logic [CELLS-1:0] b);
    logic [CELLS-1:0] r;
    int               cnt;
    int               ny;
    int               nx;
    r = '0;
    for (int y = 0; y < H; y++) begin
      for (int x = 0; x < W; x++) begin
        cnt = 0;
        for (int dy = -1; dy <= 1; dy++) begin
          for (int dx = -1; dx <= 1; dx++) begin
            ny = (y + dy + H) % H;
            nx = (x + dx + W) % W;
            if (dy != 0 || dx != 0) cnt += b[ny * W + nx];
          end
        end
        r[y * W + x] = (cnt == 3) || (b[y * W + x] && cnt == 2);
      end
    end
    return r;
  endfunction

  task automatic capture_byte(input logic [7:0] ch);
    int         p;
    int         col;
    logic [7:0] exp;
    cell_addr_t a;
    if (byte_pos < 4) begin
      case (byte_pos)
        0:       exp = `LIFE_CHAR_ESC;
        1:       exp = `LIFE_CHAR_LBRACKET;
        2:       exp = `LIFE_CHAR_SEMI;
        default: exp = `LIFE_CHAR_HOME;
      endcase
      assert (ch == exp)
        else fail_now($sformatf("home byte %0d is %h, expected %h", byte_pos, ch, exp));
    end else begin
      p   = byte_pos - 4;
      col = p % (W + 2);
      if (col < W) begin
        assert (ch == `LIFE_CHAR_ALIVE || ch == `LIFE_CHAR_DEAD)
          else fail_now($sformatf("cell byte %0d is %h, not a cell character", byte_pos, ch));
        a.y = p / (W + 2);
        a.x = col;
        cap_board[a] = (ch == `LIFE_CHAR_ALIVE);
      end else begin
        exp = (col == W) ? `LIFE_CHAR_CR : `LIFE_CHAR_LF;
        assert (ch == exp)
          else fail_now($sformatf("line end byte %0d is %h, expected %h", byte_pos, ch, exp));
      end
    end
    if (byte_pos == FRAME_BYTES - 1) begin
      frame_q.push_back(cap_board);
      byte_pos = 0;
      ->frame_done;
    end else begin
      byte_pos++;
    end
  endtask

  // transfers happen on the edge, inputs only move 2 ns later
  always @(posedge clk) begin
    if (!boot_reset && tx_beat.valid && tx_ready) begin
      tx_bytes++;
      capture_byte(tx_beat.data);
    end
  end

  always begin : compare_frames
    logic [CELLS-1:0] got;
    @(frame_done);
    while (frame_q.size() != 0) begin
      got = frame_q.pop_front();
      case (expect_kind)
        EXPECT_DEAD: assert (got == '0)
          else fail_now("first step frame after reset has live cells");
        EXPECT_LIVE: assert (got != '0)
          else fail_now("random fill frame has no live cell");
        default: assert (got == next_gen(ref_board))
          else fail_now($sformatf("frame %0d differs from next generation", frames_checked));
      endcase
      ref_board = got;
      frames_checked++;
    end
  end

  task automatic send_byte(input logic [7:0] ch);
    logic taken;
    taken   = 1'b0;
    rx_beat = '{valid: 1'b1, data: ch};
    while (!taken) begin
      @(posedge clk);
      taken = rx_ready; // value seen by the DUT at this edge
      #2;
    end
    rx_beat = '{valid: 1'b0, data: 8'h00};
  endtask

  task automatic wait_frames(input int target);
    wait (frames_checked >= target);
    @(posedge clk);
    #2;
  endtask

  task automatic check_quiet(input int cycles, input string what);
    int start;
    start = tx_bytes;
    repeat (cycles) @(posedge clk);
    #2;
    assert (tx_bytes == start)
      else fail_now($sformatf("unexpected tx bytes %s", what));
  endtask

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run hung", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    int base;
    clk            = 1'b0;
    boot_reset     = 1'b1;
    rx_beat        = '{valid: 1'b0, data: 8'h00};
    tx_ready       = 1'b0;
    tx_bytes       = 0;
    byte_pos       = 0;
    frames_checked = 0;
    cap_board      = '0;
    ref_board      = '0;
    expect_kind    = EXPECT_DEAD;
    repeat (10) @(posedge clk);
    #2;
    boot_reset = 1'b0;

    check_quiet(100, "after reset");
    send_byte(`LIFE_CMD_STEP);
    wait_frames(1);

    expect_kind = EXPECT_LIVE;
    send_byte(`LIFE_CMD_RANDOM);
    wait_frames(2);

    expect_kind = EXPECT_NEXT;
    for (int i = 0; i < 3; i++) begin
      send_byte(`LIFE_CMD_STEP);
      wait_frames(3 + i);
    end

    // auto-run frames arrive without further commands
    base = frames_checked;
    send_byte(`LIFE_CMD_RUN);
    wait_frames(base + 3);

    send_byte(`LIFE_CMD_STEP); // stops auto-run, no frame of its own
    check_quiet(QUIET_LONG, "after auto-run was stopped");

    send_byte(8'h78); // 'x' is swallowed
    check_quiet(1000, "after an unknown command");

    if (byte_pos == 0 && frame_q.size() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("** Error at %0t: run ended inside a frame", $time);
      $display("Simulation failed");
      $fatal(1, "partial frame");
    end
  end

endmodule

`default_nettype wire

//--- verification/conway_assertions.sv
/*
  game of life handshake checks
  bound to the top level; watches both byte streams for beats that
  change while stalled and for rx and tx being active together
*/
`timescale 1ns/1ps
`default_nettype none

module conway_assertions (
  input logic                 clk,
  input logic                 boot_reset,
  input life_pkg::byte_beat_t rx_beat,
  input logic                 rx_ready,
  input life_pkg::byte_beat_t tx_beat,
  input logic                 tx_ready
);
  import life_pkg::*;

  int unsigned fail_count = 0; // failed checks so far

  // a stalled beat must not change until it is taken
  property beat_holds(byte_beat_t beat, logic ready);
    @(posedge clk) disable iff (boot_reset)
      (beat.valid && !ready) |=> $stable(beat);
  endproperty

  tx_stable: assert property (beat_holds(tx_beat, tx_ready))
    else begin
      fail_count++;
      $error("tx beat changed while waiting for tx_ready");
    end

  rx_stable: assert property (beat_holds(rx_beat, rx_ready))
    else begin
      fail_count++;
      $error("rx beat changed while waiting for rx_ready");
    end

  // commands are only taken while no frame is being printed
  rx_tx_exclusive: assert property (@(posedge clk) disable iff (boot_reset)
    !(rx_ready && tx_beat.valid))
    else begin
      fail_count++;
      $error("rx_ready and tx valid high in the same cycle");
    end

endmodule

bind conway_top conway_assertions u_assert (.*);

`default_nettype wire

//--- rtl/conway_top.sv
/*
  game of life top level
  byte command stream in, ANSI text frames out; the decoder drives
  the engine, which hands each finished board to the printer
*/
`timescale 1ns/1ps
`default_nettype none

module conway_top (
  input  logic                 clk,
  input  logic                 boot_reset,
  input  life_pkg::byte_beat_t rx_beat,
  output logic                 rx_ready,
  output life_pkg::byte_beat_t tx_beat,
  input  logic                 tx_ready
);
  import life_pkg::*;

  engine_req_t engine_req;
  logic        engine_busy;
  logic        print_start;
  logic        print_done;
  logic        cell_alive;
  cell_addr_t  print_addr;

  command_decoder u_decode (
    .clk         (clk),
    .boot_reset  (boot_reset),
    .rx_beat     (rx_beat),
    .rx_ready    (rx_ready),
    .engine_busy (engine_busy),
    .engine_req  (engine_req)
  );

  life_engine u_engine (
    .clk         (clk),
    .boot_reset  (boot_reset),
    .engine_req  (engine_req),
    .engine_busy (engine_busy),
    .print_addr  (print_addr),
    .cell_alive  (cell_alive),
    .print_start (print_start),
    .print_done  (print_done)
  );

  frame_printer u_print (
    .clk         (clk),
    .boot_reset  (boot_reset),
    .print_start (print_start),
    .print_addr  (print_addr),
    .cell_alive  (cell_alive),
    .print_done  (print_done),
    .tx_beat     (tx_beat),
    .tx_ready    (tx_ready)
  );

endmodule

`default_nettype wire

//--- rtl/frame_printer.sv
/*
  frame printer
  sends an ANSI cursor-home sequence, then the board row by row as
  'O' and space characters with CR LF after each row; cell states
  are read from the engine through print_addr
*/
`timescale 1ns/1ps
`default_nettype none

`include "life_defs.svh"

module frame_printer (
  input  logic                 clk,
  input  logic                 boot_reset,
  input  logic                 print_start,
  output life_pkg::cell_addr_t print_addr,
  input  logic                 cell_alive,
  output logic                 print_done,
  output life_pkg::byte_beat_t tx_beat,
  input  logic                 tx_ready
);
  import life_pkg::*;

  localparam logic [`LIFE_WIDTH_LOG-1:0] LAST_COL = `LIFE_WIDTH_LOG'(`LIFE_WIDTH - 1);

  print_state_t state;
  logic [1:0]   home_cnt;  // position in the home sequence
  cell_addr_t   addr;
  logic         fire;
  logic [7:0]   tx_char;

  assign print_addr = addr;
  assign fire       = tx_beat.valid && tx_ready;
  // addr wraps to zero after the last cell of the last row
  assign print_done = fire && (state == PR_LF) && (addr == '0);

  always_comb begin
    case (state)
      PR_HOME: begin
        case (home_cnt)
          2'd0:    tx_char = `LIFE_CHAR_ESC;
          2'd1:    tx_char = `LIFE_CHAR_LBRACKET;
          2'd2:    tx_char = `LIFE_CHAR_SEMI;
          default: tx_char = `LIFE_CHAR_HOME;
        endcase
      end
      PR_CELLS: tx_char = cell_alive ? `LIFE_CHAR_ALIVE : `LIFE_CHAR_DEAD;
      PR_CR:    tx_char = `LIFE_CHAR_CR;
      PR_LF:    tx_char = `LIFE_CHAR_LF;
      default:  tx_char = 8'h00;
    endcase
    tx_beat.valid = (state != PR_IDLE); // one byte offered in every busy state
    tx_beat.data  = tx_char;
  end

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state    <= PR_IDLE;
      home_cnt <= '0;
      addr     <= '0;
    end else begin
      case (state)
        PR_IDLE: begin
          if (print_start) begin
            state    <= PR_HOME;
            home_cnt <= '0;
            addr     <= '0;
          end
        end

        PR_HOME: begin
          if (fire) begin
            home_cnt <= home_cnt + 1'b1;
            if (home_cnt == 2'd3) begin
              state <= PR_CELLS;
            end
          end
        end

        PR_CELLS: begin
          if (fire) begin
            addr <= addr + 1'b1;
            if (addr.x == LAST_COL) begin // end of row
              state <= PR_CR;
            end
          end
        end

        PR_CR: begin
          if (fire) begin
            state <= PR_LF;
          end
        end

        PR_LF: begin
          if (fire) begin
            state <= (addr == '0) ? PR_IDLE : PR_CELLS;
          end
        end

        default: state <= PR_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/life_engine.sv
/*
  life engine
  owns the board; fills it from an LFSR or computes the next
  generation one cell at a time (eight neighbour reads plus a
  decision cycle), copies it back and then hands over to the printer
*/
`timescale 1ns/1ps
`default_nettype none

module life_engine (
  input  logic                  clk,
  input  logic                  boot_reset,
  input  life_pkg::engine_req_t engine_req,
  output logic                  engine_busy,
  input  life_pkg::cell_addr_t  print_addr,
  output logic                  cell_alive,
  output logic                  print_start,
  input  logic                  print_done
);
  import life_pkg::*;

  localparam int          CELLS      = 2 ** $bits(cell_addr_t);
  localparam logic [15:0] LFSR_SEED  = 16'hace1;
  localparam logic [15:0] LFSR_TAPS  = 16'hb400; // x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [3:0]  NSEL_DONE  = 4'd8;

  engine_state_t    state;
  logic [CELLS-1:0] board;
  logic [CELLS-1:0] next_cells;  // next generation, shifted in cell by cell
  cell_addr_t       idx;         // cell being processed
  cell_addr_t       nb;          // neighbour being read
  logic [3:0]       nsel;        // 0..7 neighbours, 8 decides
  logic [3:0]       ncount;
  logic [15:0]      lfsr;
  logic             new_cell;
  logic             last_cell;

  assign engine_busy = (state != ENG_IDLE);
  assign cell_alive  = board[print_addr];
  assign last_cell   = (idx == cell_addr_t'(CELLS - 1));
  assign new_cell    = (board[idx] && ncount == 4'd2) || (ncount == 4'd3);

  // neighbour address, edges wrap through the field widths
  always_comb begin
    nb = idx;
    case (nsel)
      4'd0, 4'd1, 4'd2: nb.y = idx.y - 1'b1;
      4'd5, 4'd6, 4'd7: nb.y = idx.y + 1'b1;
      default:          nb.y = idx.y;
    endcase
    case (nsel)
      4'd0, 4'd3, 4'd5: nb.x = idx.x - 1'b1;
      4'd2, 4'd4, 4'd7: nb.x = idx.x + 1'b1;
      default:          nb.x = idx.x;
    endcase
  end

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state       <= ENG_IDLE;
      board       <= '0;
      idx         <= '0;
      nsel        <= '0;
      ncount      <= '0;
      print_start <= 1'b0;
      lfsr        <= LFSR_SEED;
    end else begin
      print_start <= 1'b0;
      lfsr        <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? LFSR_TAPS : 16'h0000); // free running

      case (state)
        ENG_IDLE: begin
          idx    <= '0;
          nsel   <= '0;
          ncount <= '0;
          if (engine_req.valid && engine_req.op == OP_RANDOMIZE) begin
            state <= ENG_RANDOMIZE;
          end else if (engine_req.valid && engine_req.op == OP_STEP) begin
            state <= ENG_COUNT;
          end
        end

        ENG_RANDOMIZE: begin
          board[idx] <= lfsr[0];
          idx        <= idx + 1'b1;
          if (last_cell) begin
            state       <= ENG_PRINT;
            print_start <= 1'b1;
          end
        end

        ENG_COUNT: begin
          if (nsel != NSEL_DONE) begin
            ncount <= ncount + board[nb];
            nsel   <= nsel + 1'b1;
          end else begin
            ncount <= '0;
            nsel   <= '0;
            idx    <= idx + 1'b1;
            if (last_cell) begin
              state <= ENG_COPY;
            end
          end
        end

        ENG_COPY: begin
          board[idx] <= next_cells[CELLS-1]; // cell 0 was shifted in first
          idx        <= idx + 1'b1;
          if (last_cell) begin
            state       <= ENG_PRINT;
            print_start <= 1'b1;
          end
        end

        ENG_PRINT: begin
          if (print_done) begin
            state <= ENG_IDLE;
          end
        end

        default: state <= ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ENG_COUNT && nsel == NSEL_DONE) begin
      next_cells <= {next_cells[CELLS-2:0], new_cell};
    end else if (state == ENG_COPY) begin
      next_cells <= {next_cells[CELLS-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

//--- rtl/command_decoder.sv
/*
  command decoder
  takes command bytes while the engine is idle, keeps the auto-run
  flag and its interval timer, and issues one-cycle engine requests
*/
`timescale 1ns/1ps
`default_nettype none

`include "life_defs.svh"

module command_decoder (
  input  logic                  clk,
  input  logic                  boot_reset,
  input  life_pkg::byte_beat_t  rx_beat,
  output logic                  rx_ready,
  input  logic                  engine_busy,
  output life_pkg::engine_req_t engine_req
);
  import life_pkg::*;

  localparam int TIMER_W = $clog2(`LIFE_UPDATE_INTERVAL);
  localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(`LIFE_UPDATE_INTERVAL - 1);

  logic               running;    // auto-run enabled
  logic [TIMER_W-1:0] timer;
  logic               accept;
  logic               idle;
  logic               fire;

  assign accept = rx_beat.valid && rx_ready;
  assign idle   = !engine_busy && !engine_req.valid; // nothing in flight
  // a received byte has priority over the timer in the same cycle
  assign fire   = running && idle && !accept && (timer == TIMER_LAST);

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      rx_ready   <= 1'b0;
      running    <= 1'b0;
      timer      <= '0;
      engine_req <= '{valid: 1'b0, op: OP_NONE};
    end else begin
      engine_req <= '{valid: 1'b0, op: OP_NONE};
      rx_ready   <= idle && !accept && !fire;

      if (accept) begin
        case (rx_beat.data)
          `LIFE_CMD_RANDOM: engine_req <= '{valid: 1'b1, op: OP_RANDOMIZE};
          `LIFE_CMD_STEP: begin
            if (running) begin // stops auto-run instead of stepping
              running <= 1'b0;
              timer   <= '0;
            end else begin
              engine_req <= '{valid: 1'b1, op: OP_STEP};
            end
          end
          `LIFE_CMD_RUN: begin
            running <= !running;
            timer   <= '0;
          end
          default: begin
            // any other byte is swallowed
          end
        endcase
      end else if (fire) begin
        engine_req <= '{valid: 1'b1, op: OP_STEP};
        timer      <= '0;
      end else if (running && idle) begin
        timer <= timer + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/life_pkg.sv
/*
  game of life types
  byte stream beats, engine requests and states, printer states
  and the cell address layout shared by the design and testbench
*/
`default_nettype none

`include "life_defs.svh"

package life_pkg;

  // one beat of a valid/ready byte stream
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_beat_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_RANDOMIZE,
    OP_STEP
  } engine_op_t;

  typedef struct packed {
    logic       valid;
    engine_op_t op;
  } engine_req_t;

  // row major, so the packed value is the linear cell index
  typedef struct packed {
    logic [`LIFE_HEIGHT_LOG-1:0] y;
    logic [`LIFE_WIDTH_LOG-1:0]  x;
  } cell_addr_t;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_RANDOMIZE,
    ENG_COUNT,
    ENG_COPY,
    ENG_PRINT
  } engine_state_t;

  typedef enum logic [2:0] {PR_IDLE, PR_HOME, PR_CELLS, PR_CR, PR_LF} print_state_t;

endpackage

`default_nettype wire

//--- rtl/life_defs.svh
/*
  game of life shared constants
  board geometry, auto-run interval and the character codes
  used on the command and frame byte streams
*/
`ifndef LIFE_DEFS_SVH
`define LIFE_DEFS_SVH

`define LIFE_WIDTH_LOG       5
`define LIFE_HEIGHT_LOG      4
`define LIFE_WIDTH           (1 << `LIFE_WIDTH_LOG)
`define LIFE_HEIGHT          (1 << `LIFE_HEIGHT_LOG)
`define LIFE_CELLS           (`LIFE_WIDTH * `LIFE_HEIGHT)

`define LIFE_UPDATE_INTERVAL 2000 // idle cycles between auto steps

`define LIFE_CHAR_ALIVE      8'h4f // 'O'
`define LIFE_CHAR_DEAD       8'h20
`define LIFE_CMD_RANDOM      8'h30 // '0'
`define LIFE_CMD_STEP        8'h31 // '1'
`define LIFE_CMD_RUN         8'h20 // space
`define LIFE_CHAR_ESC        8'h1b
`define LIFE_CHAR_LBRACKET   8'h5b
`define LIFE_CHAR_SEMI       8'h3b
`define LIFE_CHAR_HOME       8'h48 // 'H'
`define LIFE_CHAR_CR         8'h0d
`define LIFE_CHAR_LF         8'h0a

`endif
